/* sim.f */
+incdir+.
cpuPkg.sv
instrDecode.sv
regFile.sv
aluUnit.sv
hazardUnit.sv
executeStage.sv
cpuCore.sv
tb_cpuCore.sv

/* Makefile */
# Verilator build and run of the pipelined core testbench

SOURCES := $(wildcard *.sv) $(wildcard *.svh) sim.f

.PHONY: all run lint clean

all: run

obj_dir/Vtb_cpuCore: $(SOURCES)
	verilator --binary --timing --assert -f sim.f --top-module tb_cpuCore -o Vtb_cpuCore

run: obj_dir/Vtb_cpuCore
	@out="$$(./obj_dir/Vtb_cpuCore)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -f sim.f --top-module cpuCore

clean:
	rm -rf obj_dir

/* tbIsaModel.svh */
// Testbench-only instruction encoders and an instruction-level model that lists the stores a program makes
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// R-type: opcode, rd, rs, rt, shamt, ALU op, two spare bits
function automatic logic [31:0] rType(input aluOpT fn, input int rd, input int rs, input int rt,
                                      input int sh);
    return {OP_RTYPE, 5'(rd), 5'(rs), 5'(rt), 5'(sh), fn, 2'b00};
endfunction

// I-type: 17-bit immediate in the low bits
function automatic logic [31:0] iType(input opcodeT opc, input int rd, input int rs, input int imm);
    return {opc, 5'(rd), 5'(rs), 17'(imm)};
endfunction

function automatic logic [31:0] jType(input opcodeT opc, input int target);
    return {opc, 27'(target)};
endfunction

// Data memory contents before any store, a hash of the full address
function automatic logic [31:0] fillWord(input logic [31:0] a);
    return (a * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
endfunction

// Runs the program in imem until the jump to itself, fills expQ, returns the final PC
function automatic logic [31:0] runModel();
    logic [31:0] r [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] pc, ins, next, imm, tgt, a;
    logic [4:0]  opc, rd, rs, rt, sh, fn;
    logic        halted;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) mem[i] = fillWord(i);
    expQ.delete();
    pc = '0;
    halted = 1'b0;
    for (int step = 0; step < MODEL_STEPS && !halted; step++) begin
        ins  = imem[pc[IMEM_AW-1:0]];
        opc  = ins[31:27];
        rd   = ins[26:22];
        rs   = ins[21:17];
        rt   = ins[16:12];
        sh   = ins[11:7];
        fn   = ins[6:2];
        imm  = {{15{ins[16]}}, ins[16:0]};        // Sign-extended
        tgt  = {5'b0, ins[26:0]};
        next = pc + 1;
        case (opc)
            OP_RTYPE: begin
                case (fn)
                    ALU_ADD: r[rd] = r[rs] + r[rt];
                    ALU_SUB: r[rd] = r[rs] - r[rt];
                    ALU_AND: r[rd] = r[rs] & r[rt];
                    ALU_OR:  r[rd] = r[rs] | r[rt];
                    ALU_SLL: r[rd] = r[rs] << sh;
                    ALU_SRA: r[rd] = $signed(r[rs]) >>> sh;
                    default: ;                      // mul, div: nothing
                endcase
            end
            OP_ADDI: r[rd] = r[rs] + imm;
            OP_LW: begin
                a = r[rs] + imm;
                r[rd] = mem[a[DMEM_AW-1:0]];
            end
            OP_SW: begin
                a = r[rs] + imm;
                expQ.push_back('{addr: a, wrData: r[rd], wrEn: 1'b1});
                mem[a[DMEM_AW-1:0]] = r[rd];
            end
            OP_BNE: if (r[rd] != r[rs]) next = pc + 1 + imm;
            OP_BLT: if ($signed(r[rd]) < $signed(r[rs])) next = pc + 1 + imm;
            OP_J: begin
                halted = (tgt == pc);               // End of program
                next = tgt;
            end
            OP_JAL: begin
                r[31] = pc + 1;
                next = tgt;
            end
            OP_JR: next = r[rd];
            default: ;
        endcase
        r[0] = '0;
        pc = next;
    end
    return pc;
endfunction

`endif

/* tb_cpuCore.sv */
// Testbench for cpuCore, runs small programs and compares every data memory store with the ISA model
`timescale 1ns/10ps
`include "cpu_params.svh"

module tb_cpuCore;
    import cpuPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 12;      // Window for stray stores after the end
    localparam int IMEM_AW      = 8;
    localparam int IMEM_WORDS   = 1 << IMEM_AW;
    localparam int DMEM_AW      = 10;
    localparam int DMEM_WORDS   = 1 << DMEM_AW;
    localparam int MODEL_STEPS  = 2000;

    logic             clock, rstN;
    logic [`XLEN-1:0] imemAddr, imemData, dmemRdata;
    dmemReqT          dmemReq;

    logic [`XLEN-1:0] imem [IMEM_WORDS];
    logic [`XLEN-1:0] dmem [DMEM_WORDS];
    logic [`XLEN-1:0] prog [$];            // Program under construction
    dmemReqT          expQ [$];            // Expected stores, oldest first
    logic [31:0]      rngState = 32'd51;
    string            curTest;
    int errCount, testErrs, storesSeen, testCount, failCount, cycleCount, cycleLimit;

    `include "tbIsaModel.svh"

    cpuCore i_dut (
        .clock    (clock),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .dmemReq  (dmemReq),
        .dmemRdata(dmemRdata)
    );

    always #4 clock = ~clock;              // 8 ns period

    // Both memories answer in the same cycle
    assign imemData  = (imemAddr < IMEM_WORDS) ? imem[imemAddr[IMEM_AW-1:0]] : '0;
    assign dmemRdata = (dmemReq.addr < DMEM_WORDS) ? dmem[dmemReq.addr[DMEM_AW-1:0]]
                                                   : fillWord(dmemReq.addr);

    always @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) dmem[i] <= fillWord(i);   // Fresh per test
        end else if (dmemReq.wrEn) begin
            dmem[dmemReq.addr[DMEM_AW-1:0]] <= dmemReq.wrData;
        end
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    task automatic checkWord(input string name, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errCount++;
            testErrs++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            errCount++;
            testErrs++;
        end
    endtask

    task automatic checkReq(input string name, input dmemReqT exp, input dmemReqT act);
        checkBit({name, " wrEn"}, exp.wrEn, act.wrEn);
        checkWord({name, " addr"}, exp.addr, act.addr);
        checkWord({name, " data"}, exp.wrData, act.wrData);
    endtask

    task automatic checkResetState();
        checkBit({curTest, " reset wrEn"}, 1'b0, dmemReq.wrEn);
        checkWord({curTest, " reset imemAddr"}, '0, imemAddr);
    endtask

    // Store monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (rstN && dmemReq.wrEn) begin
            if (expQ.size() == 0) begin
                $display("%s: store of %h to %h when no store was expected",
                         curTest, dmemReq.wrData, dmemReq.addr);
                errCount++;
                testErrs++;
            end else begin
                checkReq($sformatf("%s store %0d", curTest, storesSeen), expQ.pop_front(), dmemReq);
            end
            storesSeen++;
        end
    end

    initial begin
        while (cycleCount <= cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the core never finished test %s", cycleCount, curTest);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic runTest(input string name);
        logic [31:0] endPc;
        int          expCount;
        cycleLimit += prog.size() * 20 + RESET_CYCLES + DRAIN_CYCLES + 2;
        curTest = name;
        testErrs = 0;
        storesSeen = 0;
        @(posedge clock);
        rstN <= 1'b0;
        @(posedge clock);                  // Core holds reset from this edge on
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = (i < prog.size()) ? prog[i] : '0;
        endPc = runModel();
        expCount = expQ.size();
        repeat (RESET_CYCLES - 1) begin
            @(negedge clock);
            checkResetState();
            @(posedge clock);
        end
        rstN <= 1'b1;
        @(negedge clock);
        checkResetState();                 // First cycle after release
        while (!(storesSeen >= expCount && imemAddr == endPc)) @(negedge clock);
        repeat (DRAIN_CYCLES) @(negedge clock);
        if (expQ.size() != 0) begin
            $display("%s: %0d expected stores never appeared", name, expQ.size());
            errCount++;
            testErrs++;
        end
        testCount++;
        if (testErrs != 0) failCount++;
        $display("%s: %s, %0d stores", name, (testErrs == 0) ? "ok" : "failed", storesSeen);
    endtask

    // Dependent chains, random operands
    task automatic aluTest();
        prog.delete();
        for (int k = 0; k < 2; k++) begin
            prog.push_back(iType(OP_ADDI, 1, 0, int'(nextRandom() & 32'h1FFFF)));
            prog.push_back(iType(OP_ADDI, 2, 0, int'(nextRandom() & 32'h1FFFF)));
            prog.push_back(rType(ALU_ADD, 3, 1, 2, 0));
            prog.push_back(rType(ALU_SUB, 4, 3, 1, 0));
            prog.push_back(rType(ALU_AND, 5, 4, 3, 0));
            prog.push_back(rType(ALU_OR, 6, 5, 2, 0));
            prog.push_back(rType(ALU_SLL, 7, 6, 0, int'(nextRandom() & 32'd31)));
            prog.push_back(rType(ALU_SRA, 8, 7, 0, int'(nextRandom() & 32'd31)));
            for (int r = 3; r <= 8; r++) prog.push_back(iType(OP_SW, r, 0, 16 * k + r));
        end
        prog.push_back(jType(OP_J, prog.size()));
        runTest("alu");
    endtask

    task automatic loadStoreTest();
        prog.delete();
        prog.push_back(iType(OP_ADDI, 1, 0, int'(nextRandom() & 32'h1FFFF)));
        prog.push_back(iType(OP_ADDI, 9, 0, 40));      // Base address
        prog.push_back(iType(OP_SW, 1, 9, 0));
        prog.push_back(iType(OP_ADDI, 2, 1, 5));
        prog.push_back(iType(OP_SW, 2, 9, 1));         // Data written just before
        prog.push_back(iType(OP_LW, 3, 9, 0));
        prog.push_back(rType(ALU_ADD, 4, 3, 1, 0));    // Load-use on port A
        prog.push_back(iType(OP_SW, 4, 9, 2));
        prog.push_back(iType(OP_LW, 5, 9, 1));
        prog.push_back(iType(OP_SW, 5, 9, 3));         // Loaded value as store data
        prog.push_back(iType(OP_LW, 6, 9, 2));
        prog.push_back(rType(ALU_SUB, 7, 1, 6, 0));    // Load-use on port B
        prog.push_back(iType(OP_SW, 7, 9, 4));
        prog.push_back(jType(OP_J, prog.size()));
        runTest("loadstore");
    endtask

    task automatic branchTest();
        prog.delete();
        prog.push_back(iType(OP_ADDI, 1, 0, -5));
        prog.push_back(iType(OP_ADDI, 2, 0, 3));
        prog.push_back(iType(OP_BNE, 1, 2, 1));        // Taken
        prog.push_back(iType(OP_SW, 1, 0, 70));        // Skipped
        prog.push_back(iType(OP_SW, 2, 0, 71));
        prog.push_back(iType(OP_BNE, 1, 1, 1));        // Not taken
        prog.push_back(iType(OP_SW, 1, 0, 72));
        prog.push_back(iType(OP_BLT, 1, 2, 2));        // -5 < 3, taken
        prog.push_back(iType(OP_SW, 1, 0, 73));
        prog.push_back(iType(OP_SW, 1, 0, 74));
        prog.push_back(iType(OP_BLT, 2, 1, 1));        // 3 < -5 fails
        prog.push_back(iType(OP_SW, 2, 0, 75));
        prog.push_back(rType(ALU_ADD, 3, 1, 2, 0));
        prog.push_back(iType(OP_BLT, 3, 1, 1));        // -2 < -5 fails, bypassed operand
        prog.push_back(iType(OP_SW, 3, 0, 76));
        prog.push_back(jType(OP_J, prog.size()));
        runTest("branch");
    endtask

    task automatic jumpTest();
        prog.delete();
        prog.push_back(jType(OP_JAL, 4));              // 0
        prog.push_back(iType(OP_SW, 31, 0, 80));       // 1, reached through jr
        prog.push_back(jType(OP_J, 8));                // 2
        prog.push_back(iType(OP_SW, 0, 0, 81));        // 3 never
        prog.push_back(iType(OP_SW, 31, 0, 82));       // 4 link value
        prog.push_back(iType(OP_ADDI, 5, 31, 0));      // 5
        prog.push_back(iType(OP_JR, 5, 0, 0));         // 6 target from previous instr
        prog.push_back(iType(OP_SW, 0, 0, 83));        // 7 never
        prog.push_back(iType(OP_ADDI, 6, 0, 11));      // 8
        prog.push_back(iType(OP_JR, 6, 0, 0));         // 9
        prog.push_back(iType(OP_SW, 0, 0, 84));        // 10 never
        prog.push_back(iType(OP_SW, 6, 0, 85));        // 11
        prog.push_back(jType(OP_J, 12));               // 12
        runTest("jump");
    endtask

    initial begin
        clock = 1'b0;
        rstN = 1'b0;
        aluTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        $display("%0d tests, %0d failed, %0d errors", testCount, failCount, errCount);
        if (errCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* cpuCore.sv */
// Five-stage pipelined core top level, instruction and data memories sit outside and answer combinationally
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpuCore (
    input  logic             clock,
    input  logic             rstN,
    output logic [`XLEN-1:0] imemAddr,
    input  logic [`XLEN-1:0] imemData,
    output cpuPkg::dmemReqT  dmemReq,
    input  logic [`XLEN-1:0] dmemRdata
);
    import cpuPkg::*;

    logic [`XLEN-1:0] pc;
    fetchDecodeT      fd;
    decodeExecuteT    de;
    executeMemoryT    em;
    memoryWritebackT  mw;

    decodedT          dec;
    executeMemoryT    exeOut;
    bypassSelT        bypassA, bypassB;
    logic [`XLEN-1:0] decInstr, rdA, rdB, redirectPc, wbData;
    logic             redirect, loadUseStall, storeBypass;

    assign imemAddr = pc;
    assign decInstr = fd.valid ? fd.instr : '0;   // Bubbles decode as add $r0, reads nothing

    instrDecode decoder (
        .instr(decInstr),
        .dec  (dec)
    );

    regFile regs (
        .clock    (clock),
        .rstN     (rstN),
        .readIdxA (dec.srcA),
        .readIdxB (dec.srcB),
        .writeEn  (mw.valid && mw.writesBack),
        .writeIdx (mw.dest),
        .writeData(mw.result),
        .readDataA(rdA),
        .readDataB(rdB)
    );

    hazardUnit hazards (
        .decSrcA     (dec.srcA),
        .decSrcB     (dec.srcB),
        .exe         (de),
        .mem         (em),
        .wb          (mw),
        .bypassA     (bypassA),
        .bypassB     (bypassB),
        .storeBypass (storeBypass),
        .loadUseStall(loadUseStall)
    );

    executeStage execute (
        .exe       (de),
        .bypassA   (bypassA),
        .bypassB   (bypassB),
        .memResult (em.result),
        .wbResult  (mw.result),
        .toMem     (exeOut),
        .redirect  (redirect),
        .redirectPc(redirectPc)
    );

    // Memory stage request
    assign dmemReq = '{addr:   em.result,
                       wrData: storeBypass ? mw.result : em.storeData,
                       wrEn:   em.valid && em.isStore};

    assign wbData = em.isLoad ? dmemRdata : em.result;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc       <= '0;
            fd.valid <= 1'b0;
            de.valid <= 1'b0;
            em.valid <= 1'b0;
            mw.valid <= 1'b0;
        end else begin
            // Redirect beats stall, they never come from the same instruction anyway
            if (redirect)
                pc <= redirectPc;
            else if (!loadUseStall)
                pc <= pc + 1'b1;

            if (redirect)
                fd.valid <= 1'b0;                                  // Flush wrong-path fetch
            else if (!loadUseStall)
                fd <= '{valid: 1'b1, pc: pc, instr: imemData};

            // Bubble on flush or load-use
            de <= '{valid: fd.valid && !redirect && !loadUseStall,
                    pc:    fd.pc,
                    dec:   dec,
                    opA:   rdA,
                    opB:   rdB};

            em <= exeOut;
            mw <= '{valid: em.valid, dest: em.dest, writesBack: em.writesBack, result: wbData};
        end
    end

    // A store strobe must carry a known address and data word
    assert property (@(posedge clock) disable iff (!rstN)
                     dmemReq.wrEn |-> !$isunknown({dmemReq.addr, dmemReq.wrData}))
        else $error("dmem write strobe with unknown address or data");

endmodule

/* executeStage.sv */
// Execute stage: operand bypass, immediate select, ALU, branch and jump resolution, link value
`timescale 1ns/10ps
`include "cpu_params.svh"

module executeStage (
    input  cpuPkg::decodeExecuteT exe,
    input  cpuPkg::bypassSelT     bypassA,
    input  cpuPkg::bypassSelT     bypassB,
    input  logic [`XLEN-1:0]      memResult,
    input  logic [`XLEN-1:0]      wbResult,
    output cpuPkg::executeMemoryT toMem,
    output logic                  redirect,
    output logic [`XLEN-1:0]      redirectPc
);
    import cpuPkg::*;

    logic [`XLEN-1:0] valA, valB, aluB, aluResult, pcPlusOne;
    logic             notEqual, lessThan, branchTaken;

    function automatic logic [`XLEN-1:0] pickOperand(input bypassSelT sel,
                                                     input logic [`XLEN-1:0] regVal,
                                                     input logic [`XLEN-1:0] memVal,
                                                     input logic [`XLEN-1:0] wbVal);
        case (sel)
            BYP_MEM: return memVal;
            BYP_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        valA = pickOperand(bypassA, exe.opA, memResult, wbResult);
        valB = pickOperand(bypassB, exe.opB, memResult, wbResult);
    end

    assign aluB      = exe.dec.useImm ? exe.dec.imm : valB;   // addi, lw, sw
    assign pcPlusOne = exe.pc + 1'b1;

    aluUnit alu (
        .opA     (valA),
        .opB     (aluB),
        .op      (exe.dec.aluOp),
        .shamt   (exe.dec.shamt),
        .result  (aluResult),
        .notEqual(notEqual),
        .lessThan(lessThan)
    );

    assign branchTaken = (exe.dec.isBranchNe && notEqual) || (exe.dec.isBranchLt && lessThan);

    assign redirect = exe.valid
                      && (branchTaken || exe.dec.isJump || exe.dec.isJal || exe.dec.isJr);

    always_comb begin
        if (exe.dec.isJr)
            redirectPc = valA;                        // Register target, bypassed
        else if (exe.dec.isJump || exe.dec.isJal)
            redirectPc = exe.dec.target;
        else
            redirectPc = pcPlusOne + exe.dec.imm;     // PC relative
    end

    always_comb begin
        toMem.valid      = exe.valid;
        toMem.result     = exe.dec.isJal ? pcPlusOne : aluResult;   // Link value for $r31
        toMem.storeData  = valB;
        toMem.dest       = exe.dec.dest;
        toMem.writesBack = exe.dec.writesBack;
        toMem.isLoad     = exe.dec.isLoad;
        toMem.isStore    = exe.dec.isStore;
    end

endmodule

/* hazardUnit.sv */
// Picks bypass sources for the execute operands and store data, and flags the load-use stall
`timescale 1ns/10ps
`include "cpu_params.svh"

module hazardUnit (
    input  logic [`REG_IDX_W-1:0]  decSrcA,
    input  logic [`REG_IDX_W-1:0]  decSrcB,
    input  cpuPkg::decodeExecuteT   exe,
    input  cpuPkg::executeMemoryT   mem,
    input  cpuPkg::memoryWritebackT wb,
    output cpuPkg::bypassSelT       bypassA,
    output cpuPkg::bypassSelT       bypassB,
    output logic                    storeBypass,
    output logic                    loadUseStall
);
    import cpuPkg::*;

    logic memWrites, wbWrites, exeLoads;

    assign memWrites = mem.valid && mem.writesBack;
    assign wbWrites  = wb.valid && wb.writesBack;
    assign exeLoads  = exe.valid && exe.dec.isLoad && exe.dec.writesBack;

    // Youngest producer wins, $r0 is never forwarded
    function automatic bypassSelT pickSource(input logic [`REG_IDX_W-1:0] src,
                                             input logic [`REG_IDX_W-1:0] memDest,
                                             input logic [`REG_IDX_W-1:0] wbDest);
        if (src == '0) return BYP_NONE;
        if (memWrites && memDest == src) return BYP_MEM;
        if (wbWrites && wbDest == src) return BYP_WB;
        return BYP_NONE;
    endfunction

    always_comb begin
        bypassA = pickSource(exe.dec.srcA, mem.dest, wb.dest);
        bypassB = pickSource(exe.dec.srcB, mem.dest, wb.dest);
        // Safety net on top of the execute bypass
        storeBypass = mem.valid && mem.isStore && wbWrites
                      && (mem.dest != '0) && (wb.dest == mem.dest);
        // Load result is not ready until writeback, hold decode one cycle
        loadUseStall = exeLoads
                       && (((decSrcA != '0) && (decSrcA == exe.dec.dest))
                       ||  ((decSrcB != '0) && (decSrcB == exe.dec.dest)));
        // Memory bypass carries an address for a load, the stall keeps it away
        if (exe.valid && mem.valid && mem.isLoad && (bypassA == BYP_MEM || bypassB == BYP_MEM))
            assert (1'b0) else $error("memory bypass selected from a load");
    end

endmodule

/* aluUnit.sv */
// Execute-stage ALU for the six integer ops, with not-equal and signed less-than flags for branches
`timescale 1ns/10ps
`include "cpu_params.svh"

module aluUnit (
    input  logic [`XLEN-1:0]      opA,
    input  logic [`XLEN-1:0]      opB,
    input  cpuPkg::aluOpT         op,
    input  logic [`REG_IDX_W-1:0] shamt,
    output logic [`XLEN-1:0]      result,
    output logic                  notEqual,
    output logic                  lessThan
);
    import cpuPkg::*;

    logic [`XLEN-1:0] diff;
    logic             subOvf;

    // Comparison is always taken from A - B
    assign diff   = opA - opB;
    assign subOvf = (opA[`XLEN-1] ^ opB[`XLEN-1]) & (diff[`XLEN-1] ^ opA[`XLEN-1]);

    assign notEqual = |diff;
    assign lessThan = diff[`XLEN-1] ^ subOvf;   // Signed A < B even on overflow

    always_comb begin
        case (op)
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = diff;
            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_SLL: result = opA << shamt;
            ALU_SRA: result = $signed(opA) >>> shamt;   // Sign fill
            default: result = opA + opB;
        endcase
    end

endmodule

/* regFile.sv */
// Register file with two combinational read ports, one write port and write-through to the readers
`timescale 1ns/10ps
`include "cpu_params.svh"

module regFile (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic [`REG_IDX_W-1:0] readIdxA,
    input  logic [`REG_IDX_W-1:0] readIdxB,
    input  logic                  writeEn,
    input  logic [`REG_IDX_W-1:0] writeIdx,
    input  logic [`XLEN-1:0]      writeData,
    output logic [`XLEN-1:0]      readDataA,
    output logic [`XLEN-1:0]      readDataB
);
    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wrActive;

    assign wrActive = rstN && writeEn && (writeIdx != '0);  // No writes in reset or to $r0

    always_ff @(posedge clock) begin
        if (wrActive) regs[writeIdx] <= writeData;
    end

    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_IDX_W-1:0] idx);
        if (idx == '0) return '0;
        if (wrActive && idx == writeIdx) return writeData;   // Same-cycle write shows through
        return regs[idx];
    endfunction

    always_comb begin
        readDataA = readPort(readIdxA);
        readDataB = readPort(readIdxB);
    end

    // Writeback stage must always name a real register
    assert property (@(posedge clock) disable iff (!rstN) writeEn |-> !$isunknown(writeIdx))
        else $error("regFile write with unknown index");

endmodule

/* instrDecode.sv */
// Combinational decoder, turns a raw instruction word into the decoded struct used by the pipeline
`timescale 1ns/10ps
`include "cpu_params.svh"

module instrDecode (
    input  logic [`XLEN-1:0] instr,
    output cpuPkg::decodedT  dec
);
    import cpuPkg::*;

    logic [`REG_IDX_W-1:0] rd, rs, rt;

    assign rd = instr[`RD_LSB +: `REG_IDX_W];
    assign rs = instr[`RS_LSB +: `REG_IDX_W];
    assign rt = instr[`RT_LSB +: `REG_IDX_W];

    always_comb begin
        dec        = '0;
        dec.opcode = opcodeT'(instr[`OPC_LSB +: `OPC_W]);
        dec.aluOp  = ALU_ADD;                                 // Address and addi default
        dec.shamt  = instr[`SHAMT_LSB +: `REG_IDX_W];
        dec.dest   = rd;
        dec.imm    = {{(`XLEN-`IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};
        dec.target = {{(`XLEN-`TARGET_W){1'b0}}, instr[`TARGET_W-1:0]};

        case (dec.opcode)
            OP_RTYPE: begin
                dec.aluOp = aluOpT'(instr[`ALUOP_LSB +: `OPC_W]);
                case (dec.aluOp)
                    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA: begin
                        dec.srcA       = rs;
                        dec.srcB       = rt;
                        dec.writesBack = 1'b1;
                    end
                    default: dec.aluOp = ALU_ADD;              // mul, div and spare codes do nothing
                endcase
            end
            OP_ADDI: begin
                dec.srcA       = rs;
                dec.useImm     = 1'b1;
                dec.writesBack = 1'b1;
            end
            OP_LW: begin
                dec.srcA       = rs;                           // Base register
                dec.useImm     = 1'b1;
                dec.isLoad     = 1'b1;
                dec.writesBack = 1'b1;
            end
            OP_SW: begin
                dec.srcA    = rs;
                dec.srcB    = rd;                              // Data register on port B
                dec.useImm  = 1'b1;
                dec.isStore = 1'b1;
            end
            // Branches compare rd against rs with a subtraction
            OP_BNE: begin
                dec.srcA       = rd;
                dec.srcB       = rs;
                dec.aluOp      = ALU_SUB;
                dec.isBranchNe = 1'b1;
            end
            OP_BLT: begin
                dec.srcA       = rd;
                dec.srcB       = rs;
                dec.aluOp      = ALU_SUB;
                dec.isBranchLt = 1'b1;
            end
            OP_J:   dec.isJump = 1'b1;
            OP_JAL: begin
                dec.isJal      = 1'b1;
                dec.dest       = `REG_IDX_W'(`LINK_REG);
                dec.writesBack = 1'b1;
            end
            OP_JR: begin
                dec.srcA = rd;                                 // Jump address register
                dec.isJr = 1'b1;
            end
            default: ;                                         // setx, bex, unused: bubble
        endcase

        if (dec.dest == '0) dec.writesBack = 1'b0;           // $r0 stays zero
    end

endmodule

/* cpuPkg.sv */
// Shared types for the pipelined core: opcodes, ALU ops, bypass selects and stage-register structs
`include "cpu_params.svh"

package cpuPkg;

    // Primary opcode field values
    typedef enum logic [`OPC_W-1:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_JAL   = 5'b00011,
        OP_JR    = 5'b00100,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcodeT;

    // R-type ALU op field values
    typedef enum logic [`OPC_W-1:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } aluOpT;

    typedef enum logic [1:0] {
        BYP_NONE,
        BYP_MEM,   // Result sitting in execute-memory register
        BYP_WB     // Result sitting in memory-writeback register
    } bypassSelT;

    typedef struct packed {
        opcodeT                 opcode;
        aluOpT                  aluOp;
        logic [`REG_IDX_W-1:0]  shamt;
        logic [`REG_IDX_W-1:0]  srcA;
        logic [`REG_IDX_W-1:0]  srcB;
        logic [`REG_IDX_W-1:0]  dest;       // Store data register for sw
        logic                   writesBack;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       target;
        logic                   useImm;
        logic                   isLoad;
        logic                   isStore;
        logic                   isBranchNe;
        logic                   isBranchLt;
        logic                   isJump;
        logic                   isJal;
        logic                   isJr;
    } decodedT;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } fetchDecodeT;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        decodedT          dec;
        logic [`XLEN-1:0] opA;   // Register values as read in decode
        logic [`XLEN-1:0] opB;
    } decodeExecuteT;

    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      result;     // ALU result, load/store address or link value
        logic [`XLEN-1:0]      storeData;
        logic [`REG_IDX_W-1:0] dest;
        logic                  writesBack;
        logic                  isLoad;
        logic                  isStore;
    } executeMemoryT;

    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] dest;
        logic                  writesBack;
        logic [`XLEN-1:0]      result;
    } memoryWritebackT;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wrData;
        logic             wrEn;
    } dmemReqT;

endpackage

/* cpu_params.svh */
// Core-wide widths, instruction field positions and special register numbers, included by package and RTL
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN       32   // Data and word-address width
`define REG_IDX_W  5
`define NUM_REGS   32
`define OPC_W      5    // Also the width of the R-type ALU op field
`define IMM_W      17   // I-type immediate, sign-extended
`define TARGET_W   27   // J-type target, zero-extended

// Low bit of each instruction field
`define OPC_LSB    27
`define RD_LSB     22
`define RS_LSB     17
`define RT_LSB     12
`define SHAMT_LSB  7
`define ALUOP_LSB  2

`define LINK_REG   31   // Written by jal

`endif
